/* design/ctrl_pkg.sv */
package ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [5:0] opcode_t;
    typedef logic [3:0] alu_fn_t;

    // class taken from opcode bits 5:4
    typedef enum logic [1:0] {
        ALU_REG = 2'b00,
        ALU_IMM = 2'b01,
        MEM     = 2'b10,
        ILLEGAL = 2'b11
    } op_class_e;

    function automatic op_class_e op_class(opcode_t op);
        return op_class_e'(op[5:4]);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stage payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        KIND_ALU = 1'b0,
        KIND_MEM = 1'b1
    } uop_kind_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_e;

    // fetch/decode to memory stage
    typedef struct packed {
        uop_kind_e kind;
        alu_fn_t   alu_fn;
        logic      use_imm;
        logic      store;
    } uop_t;

    // memory stage to writeback
    typedef struct packed {
        wb_sel_e wb_sel;
    } wb_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // control lines per stage
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic imem_req;
        logic ir_load;
        logic imm_load;
        logic pc_inc;
        logic illegal;
    } fetch_ctrl_t;

    typedef struct packed {
        logic    alu_en;
        alu_fn_t alu_fn;
        logic    alu_src_imm;
        logic    dmem_req;
        logic    dmem_we;
    } mem_ctrl_t;

    typedef struct packed {
        logic    rf_we;
        wb_sel_e wb_sel;
    } wb_ctrl_t;

endpackage

/* design/stage_reg.sv */
`timescale 1ns/1ps

// single-entry register between two stages
module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic full;
    T     data_q;

    // accept when empty or when the held entry leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            full <= 1'b0;
        end
        else if (in_valid && in_ready)
        begin
            full <= 1'b1;
        end
        else if (out_ready)
        begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            data_q <= in_data;
        end
    end

endmodule

/* design/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  opcode_t     instr,
    input  logic        imem_valid,
    output fetch_ctrl_t fetch_ctrl,
    output logic        uop_valid,
    input  logic        uop_ready,
    output uop_t        uop
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_DEC,
        S_IMM_REQ,
        S_ISSUE
    } state_e;

    state_e    state;
    state_e    state_next;
    opcode_t   ir;
    op_class_e ir_class;

    assign ir_class = op_class(ir);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // instruction register, loaded with the first word only
    always_ff @(posedge clk)
    begin
        if (state == S_REQ && imem_valid)
        begin
            ir <= instr;
        end
    end

    // micro-op straight from the held opcode
    always_comb
    begin
        uop.kind    = (ir_class == MEM) ? KIND_MEM : KIND_ALU;
        uop.alu_fn  = ir[3:0];
        uop.use_imm = (ir_class == ALU_IMM);
        uop.store   = (ir_class == MEM) && ir[0];
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencing and control lines
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        fetch_ctrl = '0;
        uop_valid  = 1'b0;
        case (state)
            S_IDLE:
            begin
                state_next = S_REQ;
            end
            S_REQ:
            begin
                fetch_ctrl.imem_req = 1'b1;
                if (imem_valid)
                begin
                    fetch_ctrl.ir_load = 1'b1;
                    fetch_ctrl.pc_inc  = 1'b1;
                    state_next         = S_DEC;
                end
            end
            S_DEC:
            begin
                case (ir_class)
                    ALU_IMM:
                    begin
                        // immediate request starts right here
                        fetch_ctrl.imem_req = 1'b1;
                        if (imem_valid)
                        begin
                            fetch_ctrl.imm_load = 1'b1;
                            fetch_ctrl.pc_inc   = 1'b1;
                            state_next          = S_ISSUE;
                        end
                        else
                        begin
                            state_next = S_IMM_REQ;
                        end
                    end
                    ILLEGAL:
                    begin
                        fetch_ctrl.illegal = 1'b1;
                        state_next         = S_REQ;
                    end
                    default:
                    begin
                        uop_valid  = 1'b1;
                        state_next = uop_ready ? S_REQ : S_ISSUE;
                    end
                endcase
            end
            S_IMM_REQ:
            begin
                fetch_ctrl.imem_req = 1'b1;
                if (imem_valid)
                begin
                    fetch_ctrl.imm_load = 1'b1;
                    fetch_ctrl.pc_inc   = 1'b1;
                    state_next          = S_ISSUE;
                end
            end
            S_ISSUE:
            begin
                // held here under back-pressure, no fetching
                uop_valid = 1'b1;
                if (uop_ready)
                begin
                    state_next = S_REQ;
                end
            end
            default:
            begin
                state_next = S_IDLE;
            end
        endcase
    end

endmodule

/* design/mem_sequencer.sv */
`timescale 1ns/1ps

module mem_sequencer
    import ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      op_valid,
    output logic      op_ready,
    input  uop_t      op,
    input  logic      dmem_ready,
    output mem_ctrl_t mem_ctrl,
    output logic      wb_valid,
    input  logic      wb_ready,
    output wb_op_t    wb_op
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_MREQ,
        S_HANDOFF
    } state_e;

    state_e state;
    state_e state_next;
    uop_t   cur;

    assign op_ready     = (state == S_IDLE);
    assign wb_op.wb_sel = (cur.kind == KIND_MEM) ? WB_MEM : WB_ALU;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (op_valid && op_ready)
        begin
            cur <= op;
        end
    end

    always_comb
    begin
        state_next = state;
        mem_ctrl   = '0;
        wb_valid   = 1'b0;
        case (state)
            S_IDLE:
            begin
                if (op_valid)
                begin
                    state_next = (op.kind == KIND_MEM) ? S_MREQ : S_EXEC;
                end
            end
            S_EXEC:
            begin
                // single-cycle ALU pulse, result offered at once
                mem_ctrl.alu_en      = 1'b1;
                mem_ctrl.alu_fn      = cur.alu_fn;
                mem_ctrl.alu_src_imm = cur.use_imm;
                wb_valid             = 1'b1;
                state_next           = wb_ready ? S_IDLE : S_HANDOFF;
            end
            S_MREQ:
            begin
                mem_ctrl.dmem_req = 1'b1;
                mem_ctrl.dmem_we  = cur.store;
                if (dmem_ready)
                begin
                    if (cur.store)
                    begin
                        state_next = S_IDLE;
                    end
                    else
                    begin
                        wb_valid   = 1'b1;
                        state_next = wb_ready ? S_IDLE : S_HANDOFF;
                    end
                end
            end
            S_HANDOFF:
            begin
                // writeback link stalled
                wb_valid = 1'b1;
                if (wb_ready)
                begin
                    state_next = S_IDLE;
                end
            end
            default:
            begin
                state_next = S_IDLE;
            end
        endcase
    end

endmodule

/* design/writeback_sequencer.sv */
`timescale 1ns/1ps

module writeback_sequencer
    import ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     op_valid,
    output logic     op_ready,
    input  wb_op_t   op,
    input  logic     dmem_valid,
    output wb_ctrl_t wb_ctrl
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_WAIT
    } state_e;

    state_e state;
    state_e state_next;

    // nothing new while a write or a load is pending
    assign op_ready = (state == S_IDLE);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        wb_ctrl    = '0;
        case (state)
            S_IDLE:
            begin
                if (op_valid)
                begin
                    if (op.wb_sel == WB_ALU)
                    begin
                        state_next = S_WRITE;
                    end
                    else if (dmem_valid)
                    begin
                        // load data already back in the take cycle
                        wb_ctrl.rf_we  = 1'b1;
                        wb_ctrl.wb_sel = WB_MEM;
                    end
                    else
                    begin
                        state_next = S_WAIT;
                    end
                end
            end
            S_WRITE:
            begin
                wb_ctrl.rf_we  = 1'b1;
                wb_ctrl.wb_sel = WB_ALU;
                state_next     = S_IDLE;
            end
            S_WAIT:
            begin
                if (dmem_valid)
                begin
                    wb_ctrl.rf_we  = 1'b1;
                    wb_ctrl.wb_sel = WB_MEM;
                    state_next     = S_IDLE;
                end
            end
            default:
            begin
                state_next = S_IDLE;
            end
        endcase
    end

endmodule

/* design/cpu_controller.sv */
`timescale 1ns/1ps

module cpu_controller
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  opcode_t     instr,
    input  logic        imem_valid,
    input  logic        dmem_ready,
    input  logic        dmem_valid,
    output fetch_ctrl_t fetch_ctrl,
    output mem_ctrl_t   mem_ctrl,
    output wb_ctrl_t    wb_ctrl
);

    ////////////////////////////////////////////////////////////////////////////
    // links between stages
    ////////////////////////////////////////////////////////////////////////////

    logic   issue_valid;
    logic   issue_ready;
    uop_t   issue_uop;
    logic   exec_valid;
    logic   exec_ready;
    uop_t   exec_uop;
    logic   wb_in_valid;
    logic   wb_in_ready;
    wb_op_t wb_in_op;
    logic   wb_out_valid;
    logic   wb_out_ready;
    wb_op_t wb_out_op;

    fetch_decode u_fetch_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .imem_valid (imem_valid),
        .fetch_ctrl (fetch_ctrl),
        .uop_valid  (issue_valid),
        .uop_ready  (issue_ready),
        .uop        (issue_uop)
    );

    stage_reg #(.T(uop_t)) u_issue_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (issue_uop),
        .out_valid (exec_valid),
        .out_ready (exec_ready),
        .out_data  (exec_uop)
    );

    mem_sequencer u_mem_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (exec_valid),
        .op_ready   (exec_ready),
        .op         (exec_uop),
        .dmem_ready (dmem_ready),
        .mem_ctrl   (mem_ctrl),
        .wb_valid   (wb_in_valid),
        .wb_ready   (wb_in_ready),
        .wb_op      (wb_in_op)
    );

    stage_reg #(.T(wb_op_t)) u_wb_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (wb_in_valid),
        .in_ready  (wb_in_ready),
        .in_data   (wb_in_op),
        .out_valid (wb_out_valid),
        .out_ready (wb_out_ready),
        .out_data  (wb_out_op)
    );

    writeback_sequencer u_writeback_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (wb_out_valid),
        .op_ready   (wb_out_ready),
        .op         (wb_out_op),
        .dmem_valid (dmem_valid),
        .wb_ctrl    (wb_ctrl)
    );

endmodule

/* verif/cpu_controller_asserts.sv */
`timescale 1ns/1ps

module cpu_controller_asserts
    import ctrl_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input opcode_t     instr,
    input logic        imem_valid,
    input logic        dmem_ready,
    input logic        dmem_valid,
    input fetch_ctrl_t fetch_ctrl,
    input mem_ctrl_t   mem_ctrl,
    input wb_ctrl_t    wb_ctrl,
    input logic        issue_valid,
    input logic        issue_ready,
    input uop_t        issue_uop,
    input logic        wb_in_valid,
    input logic        wb_in_ready,
    input wb_op_t      wb_in_op
);

    int fail_cnt = 0;

    // opcodes in fetch order, one queue for ALU ops and one for memory ops
    opcode_t    alu_q [8];
    opcode_t    mem_q [8];
    logic [3:0] alu_wr;
    logic [3:0] alu_rd;
    logic [3:0] mem_wr;
    logic [3:0] mem_rd;
    logic [1:0] last_class;
    opcode_t    alu_head;
    opcode_t    mem_head;
    logic       alu_any;
    logic       mem_any;

    assign alu_head = alu_q[alu_rd[2:0]];
    assign mem_head = mem_q[mem_rd[2:0]];
    assign alu_any  = (alu_wr != alu_rd);
    assign mem_any  = (mem_wr != mem_rd);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            alu_wr     <= 4'd0;
            alu_rd     <= 4'd0;
            mem_wr     <= 4'd0;
            mem_rd     <= 4'd0;
            last_class <= 2'b00;
        end
        else
        begin
            if (fetch_ctrl.ir_load)
            begin
                last_class <= instr[5:4];
                if (!instr[5])
                begin
                    alu_q[alu_wr[2:0]] <= instr;
                    alu_wr             <= alu_wr + 4'd1;
                end
                if (instr[5:4] == 2'b10)
                begin
                    mem_q[mem_wr[2:0]] <= instr;
                    mem_wr             <= mem_wr + 4'd1;
                end
            end
            if (mem_ctrl.alu_en)
                alu_rd <= alu_rd + 4'd1;
            if (mem_ctrl.dmem_req && dmem_ready)
                mem_rd <= mem_rd + 4'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // fetch and reset
    ////////////////////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> (fetch_ctrl == '0 && mem_ctrl == '0 && wb_ctrl == '0))
    else
    begin
        $error("control lines active in the first cycle after reset");
        fail_cnt++;
    end

    // a word moves only on req and valid, and loads exactly one register
    a_word_accept: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ctrl.pc_inc == (fetch_ctrl.imem_req && imem_valid) &&
        fetch_ctrl.pc_inc == (fetch_ctrl.ir_load ^ fetch_ctrl.imm_load))
    else
    begin
        $error("pc_inc, ir_load and imm_load disagree with the fetch handshake");
        fail_cnt++;
    end

    a_imm_class: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ctrl.imm_load |-> last_class == 2'b01)
    else
    begin
        $error("immediate word fetched for an opcode outside the immediate class");
        fail_cnt++;
    end

    a_illegal_flag: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ctrl.ir_load && instr[5:4] == 2'b11 |=> fetch_ctrl.illegal && !issue_valid)
    else
    begin
        $error("illegal opcode not flagged, or issued anyway");
        fail_cnt++;
    end

    a_illegal_single: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ctrl.illegal |=> !fetch_ctrl.illegal)
    else
    begin
        $error("illegal flag held longer than one cycle");
        fail_cnt++;
    end

    a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready |-> !fetch_ctrl.imem_req)
    else
    begin
        $error("instruction fetch while the issue link is stalled");
        fail_cnt++;
    end

    ////////////////////////////////////////////////////////////////////////////
    // links, memory stage and writeback
    ////////////////////////////////////////////////////////////////////////////

    a_issue_stable: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_uop))
    else
    begin
        $error("issue link dropped or changed its micro-op before transfer");
        fail_cnt++;
    end

    a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_in_valid && !wb_in_ready |=> wb_in_valid && $stable(wb_in_op))
    else
    begin
        $error("writeback link dropped or changed its op before transfer");
        fail_cnt++;
    end

    a_alu_fn: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ctrl.alu_en |-> alu_any && mem_ctrl.alu_fn == alu_head[3:0] &&
        mem_ctrl.alu_src_imm == (alu_head[5:4] == 2'b01))
    else
    begin
        $error("ALU pulse does not match the fetched opcode");
        fail_cnt++;
    end

    a_dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ctrl.dmem_req && !dmem_ready |=> mem_ctrl.dmem_req && $stable(mem_ctrl.dmem_we))
    else
    begin
        $error("data request withdrawn or changed before dmem_ready");
        fail_cnt++;
    end

    a_dmem_we: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ctrl.dmem_req |-> mem_any && mem_ctrl.dmem_we == mem_head[0])
    else
    begin
        $error("data request direction does not match the memory opcode");
        fail_cnt++;
    end

    // load data is written in the very cycle it returns
    a_load_write: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid == (wb_ctrl.rf_we && wb_ctrl.wb_sel == WB_MEM))
    else
    begin
        $error("load write does not line up with returning data");
        fail_cnt++;
    end

endmodule

bind cpu_controller cpu_controller_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .imem_valid  (imem_valid),
    .dmem_ready  (dmem_ready),
    .dmem_valid  (dmem_valid),
    .fetch_ctrl  (fetch_ctrl),
    .mem_ctrl    (mem_ctrl),
    .wb_ctrl     (wb_ctrl),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_uop   (issue_uop),
    .wb_in_valid (wb_in_valid),
    .wb_in_ready (wb_in_ready),
    .wb_in_op    (wb_in_op)
);

/* verif/tb_cpu_controller.sv */
`timescale 1ns/1ps

module tb_cpu_controller
    import ctrl_pkg::*;
();

    localparam int NUM_OPS       = 40;
    localparam int CLK_HALF      = 10;
    localparam int RESET_CYCLES  = 10;
    localparam int DRAIN_CYCLES  = 20;
    // two fetch gaps, a dmem gap and a spaced load return, with margin
    localparam int WORST_PER_OP  = 40;
    localparam int WATCHDOG_NS   =
        (RESET_CYCLES + NUM_OPS * WORST_PER_OP + DRAIN_CYCLES) * 2 * CLK_HALF;

    logic        clk = 1'b0;
    logic        rst_n;
    opcode_t     instr;
    logic        imem_valid;
    logic        dmem_ready;
    logic        dmem_valid;
    fetch_ctrl_t fetch_ctrl;
    mem_ctrl_t   mem_ctrl;
    wb_ctrl_t    wb_ctrl;

    integer  seed = 32'h9348_4477;
    opcode_t prog [NUM_OPS];
    int      fetch_idx   = 0;
    logic    imm_pending = 1'b0;
    logic [1:0] imem_gap = 2'd0;
    logic [1:0] dmem_gap = 2'd0;
    int      cyc         = 0;
    int      last_due    = 0;
    int      load_due [$];

    int cnt_pc_inc  = 0;
    int cnt_alu_en  = 0;
    int cnt_rf_alu  = 0;
    int cnt_rf_mem  = 0;
    int cnt_load    = 0;
    int cnt_store   = 0;
    int cnt_illegal = 0;
    int exp_alu, exp_imm, exp_load, exp_store, exp_illegal;
    int err_cnt     = 0;
    int assert_fails;

    always #CLK_HALF clk = ~clk;

    cpu_controller u_cpu_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .imem_valid (imem_valid),
        .dmem_ready (dmem_ready),
        .dmem_valid (dmem_valid),
        .fetch_ctrl (fetch_ctrl),
        .mem_ctrl   (mem_ctrl),
        .wb_ctrl    (wb_ctrl)
    );

    // one of each class up front, then random opcodes
    task automatic fill_program();
        logic [31:0] rnd;
        prog[0] = 6'b00_0011;
        prog[1] = 6'b01_0101;
        prog[2] = 6'b10_0000;
        prog[3] = 6'b10_0001;
        prog[4] = 6'b11_0110;
        prog[5] = 6'b10_0010;
        prog[6] = 6'b00_1111;
        prog[7] = 6'b01_1000;
        for (int i = 8; i < NUM_OPS; i++)
        begin
            rnd     = $random(seed);
            prog[i] = rnd[5:0];
        end
    endtask

    // totals from the class bits of each opcode
    task automatic compute_expected();
        exp_alu     = 0;
        exp_imm     = 0;
        exp_load    = 0;
        exp_store   = 0;
        exp_illegal = 0;
        for (int i = 0; i < NUM_OPS; i++)
        begin
            case (prog[i][5:4])
                2'b00: exp_alu++;
                2'b01:
                begin
                    exp_alu++;
                    exp_imm++;
                end
                2'b10:
                begin
                    if (prog[i][0])
                        exp_store++;
                    else
                        exp_load++;
                end
                default: exp_illegal++;
            endcase
        end
    endtask

    task automatic compare_count(string name, int got, int expected);
        if (got != expected)
        begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, expected);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory-side stimulus
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        logic [31:0] rnd;
        int          due;
        cyc = cyc + 1;
        if (!rst_n)
        begin
            imem_valid <= 1'b0;
            instr      <= prog[0];
            dmem_ready <= 1'b0;
            dmem_valid <= 1'b0;
        end
        else
        begin
            // instruction source
            if (fetch_ctrl.imem_req && imem_valid)
            begin
                if (fetch_ctrl.ir_load)
                begin
                    fetch_idx   = fetch_idx + 1;
                    imm_pending = (instr[5:4] == 2'b01);
                end
                else
                begin
                    imm_pending = 1'b0;
                end
                rnd      = $random(seed);
                imem_gap = rnd[1:0];
                if (imm_pending)
                    instr <= rnd[13:8];
                else if (fetch_idx < NUM_OPS)
                    instr <= prog[fetch_idx];
            end
            else if (imem_gap != 2'd0)
            begin
                imem_gap = imem_gap - 2'd1;
            end
            imem_valid <= (imem_gap == 2'd0) && (fetch_idx < NUM_OPS || imm_pending);

            // data side; load data returns in order, spaced apart
            if (mem_ctrl.dmem_req && dmem_ready)
            begin
                rnd      = $random(seed);
                dmem_gap = rnd[1:0];
                if (!mem_ctrl.dmem_we)
                begin
                    due = cyc + 4 + int'(rnd[4:2]);
                    if (due < last_due + 4)
                        due = last_due + 4;
                    last_due = due;
                    load_due.push_back(due);
                end
            end
            else if (dmem_gap != 2'd0)
            begin
                dmem_gap = dmem_gap - 2'd1;
            end
            dmem_ready <= (dmem_gap == 2'd0);

            if (load_due.size() != 0 && cyc >= load_due[0])
            begin
                void'(load_due.pop_front());
                dmem_valid <= 1'b1;
            end
            else
            begin
                dmem_valid <= 1'b0;
            end
        end
    end

    // event counts on the control lines
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (fetch_ctrl.pc_inc)
                cnt_pc_inc++;
            if (fetch_ctrl.illegal)
                cnt_illegal++;
            if (mem_ctrl.alu_en)
                cnt_alu_en++;
            if (mem_ctrl.dmem_req && dmem_ready && mem_ctrl.dmem_we)
                cnt_store++;
            if (mem_ctrl.dmem_req && dmem_ready && !mem_ctrl.dmem_we)
                cnt_load++;
            if (wb_ctrl.rf_we && wb_ctrl.wb_sel == WB_ALU)
                cnt_rf_alu++;
            if (wb_ctrl.rf_we && wb_ctrl.wb_sel == WB_MEM)
                cnt_rf_mem++;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the instruction list did not drain within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        rst_n      <= 1'b0;
        instr      <= '0;
        imem_valid <= 1'b0;
        dmem_ready <= 1'b0;
        dmem_valid <= 1'b0;
        fill_program();
        compute_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        wait (fetch_idx == NUM_OPS && !imm_pending);
        wait (cnt_rf_alu >= exp_alu && cnt_rf_mem >= exp_load &&
              cnt_store >= exp_store && cnt_illegal >= exp_illegal);
        // settle so that extra pulses would still be counted
        repeat (DRAIN_CYCLES) @(posedge clk);

        compare_count("pc_inc", cnt_pc_inc, NUM_OPS + exp_imm);
        compare_count("alu_en", cnt_alu_en, exp_alu);
        compare_count("rf_we_alu", cnt_rf_alu, exp_alu);
        compare_count("rf_we_mem", cnt_rf_mem, exp_load);
        compare_count("dmem_load", cnt_load, exp_load);
        compare_count("dmem_store", cnt_store, exp_store);
        compare_count("illegal", cnt_illegal, exp_illegal);

        assert_fails = u_cpu_controller.u_asserts.fail_cnt;
        $display("count errors: %0d, assertion failures: %0d", err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* vlog.f */
design/ctrl_pkg.sv
design/stage_reg.sv
design/fetch_decode.sv
design/mem_sequencer.sv
design/writeback_sequencer.sv
design/cpu_controller.sv
verif/cpu_controller_asserts.sv
verif/tb_cpu_controller.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the cpu_controller testbench with Verilator.
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_cpu_controller \
    -f vlog.f

./obj_dir/Vtb_cpu_controller +verilator+error+limit+1000 | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
